// File: tb.f
+incdir+design
design/icache_pkg.sv
design/icache_fill_if.sv
design/icache_store.sv
design/icache_lru.sv
design/icache_refill.sv
design/icache_top.sv
bench/icache_chk.sv
bench/icache_tb.sv

// File: Bender.yml
package:
  name: icache

sources:
  - include_dirs:
      - design
    files:
      - design/icache_pkg.sv
      - design/icache_fill_if.sv
      - design/icache_store.sv
      - design/icache_lru.sv
      - design/icache_refill.sv
      - design/icache_top.sv
  - target: test
    files:
      - bench/icache_chk.sv
      - bench/icache_tb.sv

// File: bench/icache_tb.sv
`timescale 1ns/1ns
`default_nettype none

module icache_tb;

    localparam int N_FETCH = 98;  // Fetches over all five tests
    localparam int MAX_LAT = 8;   // Worst memory latency in cycles

    logic        clk = 1'b0;
    logic        rst_n, fetch_req, flush, mem_rvalid;
    logic [31:0] fetch_addr, mem_rdata;
    wire logic   busy, instr_valid, hit, mem_req;
    wire logic [31:0] instr, mem_addr;

    logic [31:0] lfsr = 32'h462f_f4bd;
    logic [31:0] cur_addr, exp_instr, saved [16];
    logic        exp_hit;
    int          err_cnt = 0, n_pass = 0, n_fail = 0;

    // Reference LRU state per set
    logic [23:0] m_tag   [64][4];
    logic        m_valid [64][4];
    logic [1:0]  m_age   [64][4];

    icache_top icache_top_i (.*);

    always #2 clk = ~clk;  // 4 ns period

    // Returned word and hit flag against the reference model
    a_instr: assert property (@(posedge clk) disable iff (!rst_n)
        instr_valid |-> instr == exp_instr && hit == exp_hit)
        else begin
            err_cnt++;
            $display("error at %0t ns: fetch %h gave %h hit %b, expected %h hit %b", $time,
                     $sampled(cur_addr), $sampled(instr), $sampled(hit),
                     $sampled(exp_instr), $sampled(exp_hit));
        end

    a_maddr: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req |-> mem_addr == {cur_addr[31:2], 2'b00})  // Word aligned miss address
        else begin
            err_cnt++;
            $display("error at %0t ns: mem_addr %h for fetch %h", $time, $sampled(mem_addr),
                     cur_addr);
        end

    a_busy: assert property (@(posedge clk) disable iff (!rst_n)
        busy && !instr_valid |=> busy)
        else begin
            err_cnt++;
            $display("error at %0t ns: busy dropped before instr_valid", $time);
        end

    // Taps 32 22 2 1
    function automatic logic lfsr_step();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] draw(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};  // One step per bit
        end
        return v;
    endfunction

    // Predicts the hit flag and records the access
    function automatic logic model_access(input logic [31:0] a);
        logic [5:0] s;
        logic [1:0] old;
        int         w;
        s = a[7:2];
        w = -1;
        for (int i = 0; i < 4; i++) begin
            if (m_valid[s][i] && m_tag[s][i] == a[31:8]) w = i;
        end
        model_access = (w >= 0);
        for (int i = 0; i < 4; i++) begin
            if (w < 0 && !m_valid[s][i]) w = i;  // First empty way
        end
        for (int i = 0; i < 4; i++) begin
            if (w < 0 && m_age[s][i] == 2'd3) w = i;  // Else the oldest
        end
        old = m_age[s][w];
        for (int i = 0; i < 4; i++) begin
            if (m_age[s][i] < old) m_age[s][i]++;
        end
        m_age[s][w]   = 2'd0;
        m_valid[s][w] = 1'b1;
        m_tag[s][w]   = a[31:8];
    endfunction

    function automatic int total_errors();
        return err_cnt + icache_top_i.chk_i.fail_cnt;
    endfunction

    // Starts on a clock edge with the cache idle
    task automatic fetch(input logic [31:0] a);
        exp_hit    = model_access(a);
        exp_instr  = {a[31:2], 2'b00} ^ 32'hc0de_0000;
        cur_addr   = a;
        fetch_addr <= a;
        fetch_req  <= 1'b1;
        @(posedge clk);
        fetch_req <= 1'b0;
        do @(posedge clk); while (!instr_valid);
    endtask

    task automatic end_test(input string name, input int mark);
        repeat (2) @(posedge clk);  // Let pending checks settle
        if (total_errors() == mark) begin
            n_pass++;
            $display("test %s: ok", name);
        end else begin
            n_fail++;
            $display("test %s: %0d errors", name, total_errors() - mark);
        end
    endtask

    // Memory answers after 1 to 8 cycles
    always begin
        int          lat;
        logic [31:0] a;
        @(posedge clk);
        if (mem_req) begin
            lat = 1 + draw(3);
            a   = mem_addr;
            repeat (lat - 1) @(posedge clk);
            mem_rdata  <= a ^ 32'hc0de_0000;
            mem_rvalid <= 1'b1;
            @(posedge clk);
            mem_rvalid <= 1'b0;
        end
    end

    initial begin
        int mark;
        rst_n = 1'b0;
        fetch_req = 1'b0;
        fetch_addr = '0;
        flush = 1'b0;
        mem_rvalid = 1'b0;
        mem_rdata = '0;
        for (int s = 0; s < 64; s++) begin
            for (int w = 0; w < 4; w++) begin
                m_valid[s][w] = 1'b0;
                m_age[s][w]   = 2'(w);  // Reset order of the ages
            end
        end
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        mark = total_errors();
        fetch(32'h0000_1234);
        fetch(32'h0000_1236);  // Same line, other offset
        end_test("cold miss then hit", mark);

        mark = total_errors();
        for (int i = 0; i < 6; i++) begin
            fetch({24'h100 + 24'(i == 4 ? 0 : (i == 5 ? 4 : i)), 6'h15, 2'b00});  // A B C D A E
        end
        fetch({24'h100, 6'h15, 2'b00});
        fetch({24'h101, 6'h15, 2'b00});  // B was evicted by E
        end_test("replacement order", mark);

        mark = total_errors();
        for (int i = 0; i < 16; i++) begin
            saved[i] = (draw(24) << 8) | ((i * 4 + draw(2)) << 2) | draw(2);  // Distinct sets
            fetch(saved[i]);
        end
        for (int i = 0; i < 16; i++) fetch(saved[i]);
        end_test("set independence", mark);

        mark = total_errors();
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        for (int s = 0; s < 64; s++) begin
            for (int w = 0; w < 4; w++) m_valid[s][w] = 1'b0;  // Ages survive a flush
        end
        for (int i = 0; i < 16; i++) fetch(saved[i]);
        for (int i = 0; i < 16; i++) fetch(saved[i]);
        end_test("flush", mark);

        mark = total_errors();
        for (int i = 0; i < 24; i++) fetch(draw(32));
        end_test("random latency", mark);

        $display("tests passed %0d failed %0d", n_pass, n_fail);
        if (n_fail == 0 && total_errors() == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

    // Worst case every fetch misses at full latency
    initial begin
        #(N_FETCH * (MAX_LAT + 4) * 4 + 2000);
        $display("run timed out, the cache stopped answering fetches");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/icache_chk.sv
`timescale 1ns/1ns
`default_nettype none

// Port protocol checks on the cache top level
module icache_chk (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic fetch_req,
    input wire logic busy,
    input wire logic instr_valid,
    input wire logic hit,
    input wire logic mem_req,
    input wire logic mem_rvalid
);

    int fail_cnt = 0;  // Failed assertions so far

    // Accepted fetch without a miss answers one cycle later as a hit
    a_hit_turn: assert property (@(posedge clk) disable iff (!rst_n)
        (fetch_req && !busy) ##1 !mem_req |-> instr_valid && hit)
        else begin
            fail_cnt++;
            $error("hit not returned one cycle after the fetch");
        end

    a_refill_turn: assert property (@(posedge clk) disable iff (!rst_n)
        mem_rvalid |=> instr_valid && !hit)  // Refilled word one cycle after memory data
        else begin
            fail_cnt++;
            $error("refilled word not returned one cycle after memory data");
        end

    // Miss goes out only in the cycle after an accepted fetch
    a_req_origin: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req |-> $past(fetch_req && !busy))
        else begin
            fail_cnt++;
            $error("memory request without a fetch one cycle before");
        end

    a_idle_reset: assert property (@(posedge clk) $rose(rst_n) |-> !busy)
        else begin
            fail_cnt++;
            $error("cache busy right after reset");
        end

    a_idle_after: assert property (@(posedge clk) disable iff (!rst_n)
        instr_valid |=> !busy)  // Ready again once the word is out
        else begin
            fail_cnt++;
            $error("cache still busy after returning a word");
        end

endmodule

bind icache_top icache_chk chk_i (.*);

`default_nettype wire

// File: design/icache_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "icache_consts.svh"

module icache_top
    import icache_pkg::*;
(
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    // Core side
    input  wire logic                      fetch_req,
    input  wire logic [`ICACHE_ADDR_W-1:0] fetch_addr,
    output logic                           busy,
    output logic                           instr_valid,
    output logic [`ICACHE_DATA_W-1:0]      instr,
    output logic                           hit,
    input  wire logic                      flush,
    // Main memory side
    output logic                           mem_req,
    output logic [`ICACHE_ADDR_W-1:0]      mem_addr,
    input  wire logic                      mem_rvalid,
    input  wire logic [`ICACHE_DATA_W-1:0] mem_rdata
);

    index_t                    lookup_index;
    tag_t                      lookup_tag;
    logic                      store_hit;
    way_t                      store_way;
    logic [`ICACHE_DATA_W-1:0] store_instr;
    logic [`ICACHE_WAYS-1:0]   valid_ways;
    way_t                      victim_way;
    logic                      access;
    way_t                      access_way;

    icache_fill_if fill_if ();  // Refill to arrays

    icache_store store_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .hit          (store_hit),
        .hit_way      (store_way),
        .hit_instr    (store_instr),
        .valid_ways   (valid_ways),
        .fill         (fill_if.store)
    );

    icache_lru lru_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .index      (lookup_index),
        .access     (access),
        .access_way (access_way),
        .valid_ways (valid_ways),
        .victim_way (victim_way)
    );

    icache_refill refill_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_req    (fetch_req),
        .fetch_addr   (fetch_addr),
        .busy         (busy),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .hit          (hit),
        .mem_req      (mem_req),
        .mem_addr     (mem_addr),
        .mem_rvalid   (mem_rvalid),
        .mem_rdata    (mem_rdata),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .store_hit    (store_hit),
        .store_way    (store_way),
        .store_instr  (store_instr),
        .victim_way   (victim_way),
        .access       (access),
        .access_way   (access_way),
        .fill         (fill_if.refill)
    );

endmodule

`default_nettype wire

// File: design/icache_refill.sv
`timescale 1ns/1ns
`default_nettype none

`include "icache_consts.svh"

module icache_refill
    import icache_pkg::*;
(
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      fetch_req,
    input  wire logic [`ICACHE_ADDR_W-1:0] fetch_addr,
    output logic                           busy,
    output logic                           instr_valid,
    output logic [`ICACHE_DATA_W-1:0]      instr,
    output logic                           hit,
    output logic                           mem_req,
    output logic [`ICACHE_ADDR_W-1:0]      mem_addr,
    input  wire logic                      mem_rvalid,
    input  wire logic [`ICACHE_DATA_W-1:0] mem_rdata,
    output index_t                         lookup_index,
    output tag_t                           lookup_tag,
    input  wire logic                      store_hit,
    input  wire way_t                      store_way,
    input  wire logic [`ICACHE_DATA_W-1:0] store_instr,
    input  wire way_t                      victim_way,
    output logic                           access,
    output way_t                           access_way,
    icache_fill_if.refill                  fill
);

    refill_state_e state_q, state_d;

    logic [`ICACHE_ADDR_W-1:OFFSET_W] line_q;   // Fetch address without byte offset
    way_t                             victim_q; // Way picked at the miss
    logic [`ICACHE_DATA_W-1:0]        rdata_q;  // Refilled word for RETURN

    logic lookup_hit;
    logic lookup_miss;
    logic fill_now;

    assign lookup_hit  = (state_q == LOOKUP) && store_hit;
    assign lookup_miss = (state_q == LOOKUP) && !store_hit;
    assign fill_now    = (state_q == MEM_WAIT) && mem_rvalid;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:     if (fetch_req) state_d = LOOKUP;
            LOOKUP:   state_d = store_hit ? IDLE : MEM_WAIT;
            MEM_WAIT: if (mem_rvalid) state_d = RETURN;
            RETURN:   state_d = IDLE;
            default:  state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) state_q <= IDLE;
        else        state_q <= state_d;
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if ((state_q == IDLE) && fetch_req) line_q <= fetch_addr[`ICACHE_ADDR_W-1:OFFSET_W];
        if (lookup_miss)                    victim_q <= victim_way;  // Set is frozen until fill
        if (fill_now)                       rdata_q <= mem_rdata;
    end

    // Lookup fields from the registered address
    assign lookup_index = line_q[OFFSET_W +: INDEX_W];
    assign lookup_tag   = line_q[`ICACHE_ADDR_W-1 -: TAG_W];

    // Core side
    assign busy        = (state_q != IDLE);                 // Drops the cycle after instr_valid
    assign instr_valid = lookup_hit || (state_q == RETURN);
    assign hit         = lookup_hit;                        // Low for a refilled word
    assign instr       = (state_q == RETURN) ? rdata_q : store_instr;

    // Memory side, word aligned
    assign mem_req  = lookup_miss;
    assign mem_addr = {line_q, {OFFSET_W{1'b0}}};

    // Age update on a hit or on the fill edge
    assign access     = lookup_hit || fill_now;
    assign access_way = lookup_hit ? store_way : victim_q;

    // Fill straight from the memory bus
    assign fill.wr    = fill_now;
    assign fill.index = lookup_index;
    assign fill.way   = victim_q;
    assign fill.tag   = lookup_tag;
    assign fill.instr = mem_rdata;

endmodule

`default_nettype wire

// File: design/icache_lru.sv
`timescale 1ns/1ns
`default_nettype none

`include "icache_consts.svh"

module icache_lru
    import icache_pkg::*;
(
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire index_t                    index,       // Set being looked up or filled
    input  wire logic                      access,      // Hit or refill on this edge
    input  wire way_t                      access_way,
    input  wire logic [`ICACHE_WAYS-1:0]   valid_ways,
    output way_t                           victim_way
);

    // One age per way per set, a permutation of 0..3 in every set
    age_t [`ICACHE_SETS-1:0][`ICACHE_WAYS-1:0] age_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                for (int w = 0; w < `ICACHE_WAYS; w++) begin
                    age_q[s][w] <= age_t'(w);  // Way 0 youngest, way 3 oldest
                end
            end
        end else if (access) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                if (way_t'(w) == access_way) begin
                    age_q[index][w] <= '0;                           // Becomes most recent
                end else if (age_q[index][w] < age_q[index][access_way]) begin
                    age_q[index][w] <= age_q[index][w] + age_t'(1);  // Shift down one place
                end
                // Older ways keep their age
            end
        end
    end

    // Victim choice
    // Descending loops so the lowest-numbered match is the last assignment
    always_comb begin
        victim_way = '0;
        for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
            if (age_q[index][w] == age_t'(`ICACHE_WAYS - 1)) begin
                victim_way = way_t'(w);  // Least recently used
            end
        end
        for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
            if (!valid_ways[w]) begin
                victim_way = way_t'(w);  // Empty way overrides the age pick
            end
        end
    end

endmodule

`default_nettype wire

// File: design/icache_store.sv
`timescale 1ns/1ns
`default_nettype none

`include "icache_consts.svh"

module icache_store
    import icache_pkg::*;
(
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      flush,        // Invalidate every line
    input  wire index_t                    lookup_index,
    input  wire tag_t                      lookup_tag,
    output logic                           hit,
    output way_t                           hit_way,
    output logic [`ICACHE_DATA_W-1:0]      hit_instr,
    output logic [`ICACHE_WAYS-1:0]        valid_ways,   // Valid bits of the looked-up set
    icache_fill_if.store                   fill
);

    // Line storage, tag and word per way
    tag_t                      tag_mem   [`ICACHE_SETS][`ICACHE_WAYS];
    logic [`ICACHE_DATA_W-1:0] instr_mem [`ICACHE_SETS][`ICACHE_WAYS];

    // Valid bits kept packed so a flush clears them in one go
    logic [`ICACHE_SETS-1:0][`ICACHE_WAYS-1:0] valid_q;

    // Flush beats a fill on the same edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (flush) begin
            valid_q <= '0;
        end else if (fill.wr) begin
            valid_q[fill.index][fill.way] <= 1'b1;  // Line now holds a real word
        end
    end

    // Payload write, valid bit decides whether it counts
    always_ff @(posedge clk) begin
        if (fill.wr) begin
            tag_mem[fill.index][fill.way]   <= fill.tag;
            instr_mem[fill.index][fill.way] <= fill.instr;
        end
    end

    // Four-way compare on the registered address
    always_comb begin
        hit       = 1'b0;
        hit_way   = '0;
        hit_instr = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (valid_q[lookup_index][w] && (tag_mem[lookup_index][w] == lookup_tag)) begin
                hit       = 1'b1;                          // At most one way matches
                hit_way   = way_t'(w);
                hit_instr = instr_mem[lookup_index][w];
            end
        end
    end

    // Empty ways are preferred victims
    assign valid_ways = valid_q[lookup_index];

endmodule

`default_nettype wire

// File: design/icache_fill_if.sv
`timescale 1ns/1ns
`default_nettype none

`include "icache_consts.svh"

// One line write from the refill controller into the arrays
interface icache_fill_if
    import icache_pkg::*;
();

    logic                      wr;     // Write strobe, takes effect on the edge
    index_t                    index;  // Target set
    way_t                      way;    // Victim way
    tag_t                      tag;    // New tag for the line
    logic [`ICACHE_DATA_W-1:0] instr;  // Word fetched from memory

    modport refill (
        output wr,
        output index,
        output way,
        output tag,
        output instr
    );

    modport store (
        input wr,
        input index,
        input way,
        input tag,
        input instr
    );

endinterface

`default_nettype wire

// File: design/icache_pkg.sv
`default_nettype none

`include "icache_consts.svh"

package icache_pkg;

    // Address split: | tag | index | offset |
    localparam int OFFSET_W = 2;                                 // Byte offset within a word
    localparam int INDEX_W  = $clog2(`ICACHE_SETS);              // 6 bits for 64 sets
    localparam int TAG_W    = `ICACHE_ADDR_W - INDEX_W - OFFSET_W; // Remaining upper bits
    localparam int WAY_W    = $clog2(`ICACHE_WAYS);

    typedef logic [INDEX_W-1:0] index_t;   // Set select
    typedef logic [TAG_W-1:0]   tag_t;     // Stored per line
    typedef logic [WAY_W-1:0]   way_t;     // Way number within a set

    // 0 is most recently used, 3 least
    typedef logic [WAY_W-1:0]   age_t;

    // Refill controller states
    typedef enum logic [1:0] {
        IDLE,      // Waiting for a fetch
        LOOKUP,    // Tag compare on the registered address
        MEM_WAIT,  // Miss outstanding at main memory
        RETURN     // Refilled word goes back to the core
    } refill_state_e;

endpackage

`default_nettype wire

// File: design/icache_consts.svh
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// Instruction cache geometry
// One 32-bit instruction per line, so a line is one word

// Byte address width seen by the core and by main memory
`define ICACHE_ADDR_W 32

// Instruction word width
`define ICACHE_DATA_W 32

// Sets per way, 6 index bits above the byte offset
`define ICACHE_SETS 64

// Ways per set
`define ICACHE_WAYS 4

`endif
